//--- Makefile
# Verilator simulation of the analog front-end testbench

VERILATOR ?= verilator
TOP       ?= analog_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Something failed" $(LOG) || ! grep -q "Everything OK" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/adc_capture.sv
// two-channel ADC capture, offset binary to two's complement with overrange flags
`timescale 1ns/100ps
`default_nettype none

module adc_capture (
  input  wire                          adc_clk,
  input  wire                          rst_i,
  input  wire  [analog_pkg::ADC_W-1:0] adc_dat_a_i,  // raw offset binary, ch A
  input  wire  [analog_pkg::ADC_W-1:0] adc_dat_b_i,  // raw offset binary, ch B
  output logic [analog_pkg::ADC_W-1:0] adc_dat_a_o,  // two's complement, ch A
  output logic [analog_pkg::ADC_W-1:0] adc_dat_b_o,  // two's complement, ch B
  output logic                         adc_ovr_a_o,  // code at either rail, ch A
  output logic                         adc_ovr_b_o   // code at either rail, ch B
);

  import analog_pkg::*;

  logic [ADC_W-1:0] adc_a_q;  // pin-side register, ch A
  logic [ADC_W-1:0] adc_b_q;  // pin-side register, ch B

  // first stage, keep it next to the pads
  always_ff @(posedge adc_clk) begin
    adc_a_q <= adc_dat_a_i;  // no logic before this flop
    adc_b_q <= adc_dat_b_i;
  end

  // second stage, format conversion
  always_ff @(posedge adc_clk) begin
    adc_dat_a_o <= {~adc_a_q[ADC_W-1], adc_a_q[ADC_W-2:0]};  // msb flip
    adc_dat_b_o <= {~adc_b_q[ADC_W-1], adc_b_q[ADC_W-2:0]};
  end

  // rail detect, same stage as the data so both stay aligned
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      adc_ovr_a_o <= 1'b0;
      adc_ovr_b_o <= 1'b0;
    end else begin
      adc_ovr_a_o <= (&adc_a_q) | (~|adc_a_q);  // full scale or zero code
      adc_ovr_b_o <= (&adc_b_q) | (~|adc_b_q);
    end
  end

endmodule

`default_nettype wire

//--- design/analog_ctrl.sv
// PWM settings control, host req/ack handshake with shadow words moved on frame sync
`timescale 1ns/100ps
`default_nettype none

module analog_ctrl (
  input  wire                               adc_clk,
  input  wire                               rst_i,
  input  wire                               cfg_req_i,     // host request
  input  wire  [analog_pkg::PWM_CH_W-1:0]   cfg_ch_i,      // target channel
  input  wire  [analog_pkg::PWM_WORD_W-1:0] cfg_word_i,    // new setting
  input  wire                               frame_sync_i,  // from pwm_dac
  output logic                              cfg_ack_o,     // handshake ack
  output logic [analog_pkg::PWM_WORD_W-1:0] pwm_word_a_o,  // active words
  output logic [analog_pkg::PWM_WORD_W-1:0] pwm_word_b_o,
  output logic [analog_pkg::PWM_WORD_W-1:0] pwm_word_c_o,
  output logic [analog_pkg::PWM_WORD_W-1:0] pwm_word_d_o
);

  import analog_pkg::*;

  logic                  state_q;                // idle or acked
  logic                  wr_en;                  // accept the request
  logic [PWM_WORD_W-1:0] shadow_q [PWM_CH_N];    // host-written words

  assign wr_en     = (state_q == CFG_IDLE) && cfg_req_i;
  assign cfg_ack_o = state_q == CFG_ACKED;  // straight from state flop

  // four-phase handshake
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      state_q <= CFG_IDLE;
    end else begin
      case (state_q)
        CFG_IDLE:  if (cfg_req_i) state_q <= CFG_ACKED;   // word taken this edge
        CFG_ACKED: if (!cfg_req_i) state_q <= CFG_IDLE;   // release ack
        default:   state_q <= CFG_IDLE;
      endcase
    end
  end

  // shadow registers
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      for (int i = 0; i < PWM_CH_N; i++) begin
        shadow_q[i] <= '0;
      end
    end else if (wr_en) begin
      shadow_q[cfg_ch_i] <= cfg_word_i;
    end
  end

  // active words change only at frame start
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      pwm_word_a_o <= '0;
      pwm_word_b_o <= '0;
      pwm_word_c_o <= '0;
      pwm_word_d_o <= '0;
    end else if (frame_sync_i) begin
      pwm_word_a_o <= shadow_q[0];  // all four move together
      pwm_word_b_o <= shadow_q[1];
      pwm_word_c_o <= shadow_q[2];
      pwm_word_d_o <= shadow_q[3];
    end
  end

  // ack only ever answers a request
  assert property (@(posedge adc_clk) disable iff (rst_i)
    $rose(cfg_ack_o) |-> $past(cfg_req_i));

  // host keeps the channel steady until acked
  assert property (@(posedge adc_clk) disable iff (rst_i)
    (cfg_req_i && !cfg_ack_o) |=> $stable(cfg_ch_i));

endmodule

`default_nettype wire

//--- design/analog_pkg.sv
// analog front-end package, shared data widths and PWM timing constants
`default_nettype none

package analog_pkg;

  // sample widths
  localparam int ADC_W      = 14;  // ADC channel width
  localparam int DAC_W      = 14;  // DAC channel width

  // pwm setting word, duty on top, dither below
  localparam int PWM_DUTY_W = 8;   // base duty field
  localparam int PWM_DITH_W = 16;  // dither pattern, also periods per frame
  localparam int PWM_WORD_W = 24;  // duty + dither

  // pwm timing
  localparam int PWM_PERIOD = 156; // cycles per period, max useful duty
  localparam int PWM_CNT_W  = 8;   // period counter width
  localparam int PWM_SUB_W  = 4;   // sub-period counter width, 16 periods

  // channel count
  localparam int PWM_CH_N   = 4;   // slow DAC outputs
  localparam int PWM_CH_W   = 2;   // channel index width

  // config handshake FSM states
  localparam logic CFG_IDLE  = 1'b0;  // waiting for req
  localparam logic CFG_ACKED = 1'b1;  // ack up, waiting for req to drop

endpackage

`default_nettype wire

//--- design/analog_top.sv
// analog front-end top, ADC capture, DAC interleave, PWM DACs and their control
`timescale 1ns/100ps
`default_nettype none

module analog_top (
  input  wire                               adc_clk,
  input  wire                               rst_i,
  input  wire  [analog_pkg::ADC_W-1:0]      adc_dat_a_i,  // ADC pins
  input  wire  [analog_pkg::ADC_W-1:0]      adc_dat_b_i,
  input  wire  [analog_pkg::DAC_W-1:0]      dac_dat_a_i,  // DAC samples from user logic
  input  wire  [analog_pkg::DAC_W-1:0]      dac_dat_b_i,
  input  wire                               cfg_req_i,    // host handshake
  input  wire  [analog_pkg::PWM_CH_W-1:0]   cfg_ch_i,
  input  wire  [analog_pkg::PWM_WORD_W-1:0] cfg_word_i,
  output logic [analog_pkg::ADC_W-1:0]      adc_dat_a_o,  // converted ADC data
  output logic [analog_pkg::ADC_W-1:0]      adc_dat_b_o,
  output logic                              adc_ovr_a_o,
  output logic                              adc_ovr_b_o,
  output logic [analog_pkg::DAC_W-1:0]      dac_dat_o,    // DAC pins
  output logic                              dac_wrt_o,
  output logic                              dac_sel_o,
  output logic [analog_pkg::PWM_CH_N-1:0]   pwm_o,        // slow DAC pins
  output logic                              pwm_sync_o,
  output logic                              cfg_ack_o
);

  import analog_pkg::*;

  logic [PWM_WORD_W-1:0] pwm_word_a;  // active settings, ctrl to pwm
  logic [PWM_WORD_W-1:0] pwm_word_b;
  logic [PWM_WORD_W-1:0] pwm_word_c;
  logic [PWM_WORD_W-1:0] pwm_word_d;
  logic                  frame_sync;  // also out as pwm_sync_o

  analog_ctrl u_ctrl (
    .adc_clk(adc_clk), .rst_i(rst_i),
    .cfg_req_i(cfg_req_i), .cfg_ch_i(cfg_ch_i), .cfg_word_i(cfg_word_i),
    .frame_sync_i(frame_sync), .cfg_ack_o(cfg_ack_o),
    .pwm_word_a_o(pwm_word_a), .pwm_word_b_o(pwm_word_b),
    .pwm_word_c_o(pwm_word_c), .pwm_word_d_o(pwm_word_d)
  );

  adc_capture u_adc (
    .adc_clk(adc_clk), .rst_i(rst_i),
    .adc_dat_a_i(adc_dat_a_i), .adc_dat_b_i(adc_dat_b_i),
    .adc_dat_a_o(adc_dat_a_o), .adc_dat_b_o(adc_dat_b_o),
    .adc_ovr_a_o(adc_ovr_a_o), .adc_ovr_b_o(adc_ovr_b_o)
  );

  dac_interleave u_dac (
    .adc_clk(adc_clk), .rst_i(rst_i),
    .dac_dat_a_i(dac_dat_a_i), .dac_dat_b_i(dac_dat_b_i),
    .dac_dat_o(dac_dat_o), .dac_wrt_o(dac_wrt_o), .dac_sel_o(dac_sel_o)
  );

  pwm_dac u_pwm (
    .adc_clk(adc_clk), .rst_i(rst_i),
    .pwm_word_a_i(pwm_word_a), .pwm_word_b_i(pwm_word_b),
    .pwm_word_c_i(pwm_word_c), .pwm_word_d_i(pwm_word_d),
    .pwm_o(pwm_o), .frame_sync_o(frame_sync)
  );

  assign pwm_sync_o = frame_sync;  // exported for frame alignment

endmodule

`default_nettype wire

//--- design/dac_interleave.sv
// two-channel DAC interleaver onto one offset-binary bus with write and select strobes
`timescale 1ns/100ps
`default_nettype none

module dac_interleave (
  input  wire                          adc_clk,
  input  wire                          rst_i,
  input  wire  [analog_pkg::DAC_W-1:0] dac_dat_a_i,  // two's complement, ch A
  input  wire  [analog_pkg::DAC_W-1:0] dac_dat_b_i,  // two's complement, ch B
  output logic [analog_pkg::DAC_W-1:0] dac_dat_o,    // offset binary, shared bus
  output logic                         dac_wrt_o,    // write strobe
  output logic                         dac_sel_o     // high in A slot
);

  import analog_pkg::*;

  logic             phase_q;  // high during an A slot
  logic             wrt_q;    // bus running
  logic [DAC_W-1:0] dat_b_q;  // B sample held for the second slot

  // slot phase and strobes
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      phase_q <= 1'b0;  // first edge out of reset opens A
      wrt_q   <= 1'b0;
    end else begin
      phase_q <= ~phase_q;  // A, B, A, B ...
      wrt_q   <= 1'b1;
    end
  end

  // pair is sampled together at the A edge
  always_ff @(posedge adc_clk) begin
    if (!phase_q) begin
      dac_dat_o <= {~dac_dat_a_i[DAC_W-1], dac_dat_a_i[DAC_W-2:0]};  // A now
      dat_b_q   <= dac_dat_b_i;  // B waits one cycle
    end else begin
      dac_dat_o <= {~dat_b_q[DAC_W-1], dat_b_q[DAC_W-2:0]};  // B slot
    end
  end

  assign dac_sel_o = phase_q;  // select follows slot phase
  assign dac_wrt_o = wrt_q;

  // once writing, select must alternate every cycle
  assert property (@(posedge adc_clk) disable iff (rst_i)
    dac_wrt_o |=> dac_sel_o != $past(dac_sel_o));

endmodule

`default_nettype wire

//--- design/pwm_dac.sv
// four-channel dithered PWM generator with shared period and frame counters
`timescale 1ns/100ps
`default_nettype none

module pwm_dac (
  input  wire                               adc_clk,
  input  wire                               rst_i,
  input  wire  [analog_pkg::PWM_WORD_W-1:0] pwm_word_a_i,  // duty and dither, ch A
  input  wire  [analog_pkg::PWM_WORD_W-1:0] pwm_word_b_i,
  input  wire  [analog_pkg::PWM_WORD_W-1:0] pwm_word_c_i,
  input  wire  [analog_pkg::PWM_WORD_W-1:0] pwm_word_d_i,
  output logic [analog_pkg::PWM_CH_N-1:0]   pwm_o,         // one bit per channel
  output logic                              frame_sync_o   // start of frame
);

  import analog_pkg::*;

  localparam int HI_W = PWM_DUTY_W + 1;  // duty plus one dither bit

  logic [PWM_CNT_W-1:0]  per_cnt;               // cycle within period
  logic [PWM_SUB_W-1:0]  sub_cnt;               // period within frame
  logic                  per_last;              // last cycle of a period
  logic                  frame_last;            // last cycle of a frame
  logic [PWM_WORD_W-1:0] word [PWM_CH_N];       // channel words as array
  logic [PWM_CH_N-1:0]   pwm_nxt;               // compare results

  assign word[0] = pwm_word_a_i;
  assign word[1] = pwm_word_b_i;
  assign word[2] = pwm_word_c_i;
  assign word[3] = pwm_word_d_i;

  assign per_last   = per_cnt == PWM_CNT_W'(PWM_PERIOD - 1);
  assign frame_last = per_last && (sub_cnt == PWM_SUB_W'(PWM_DITH_W - 1));

  // shared counters
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      per_cnt <= '0;
      sub_cnt <= '0;
    end else if (per_last) begin
      per_cnt <= '0;
      sub_cnt <= sub_cnt + 1'b1;  // wraps 15 -> 0
    end else begin
      per_cnt <= per_cnt + 1'b1;
    end
  end

  // per-channel high time
  for (genvar i = 0; i < PWM_CH_N; i++) begin : g_ch
    logic [PWM_DUTY_W-1:0] duty;      // base duty
    logic [PWM_DITH_W-1:0] dither;    // per-period extra cycle
    logic [HI_W-1:0]       high_raw;  // duty + dither bit
    logic [HI_W-1:0]       high_lim;  // clipped to one period

    assign duty     = word[i][PWM_WORD_W-1 -: PWM_DUTY_W];
    assign dither   = word[i][PWM_DITH_W-1:0];
    assign high_raw = {1'b0, duty} + HI_W'(dither[sub_cnt]);
    assign high_lim = (high_raw > HI_W'(PWM_PERIOD)) ? HI_W'(PWM_PERIOD) : high_raw;
    assign pwm_nxt[i] = {1'b0, per_cnt} < high_lim;  // high early in period
  end

  // registered outputs, sync lands with counters at zero
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      pwm_o        <= '0;
      frame_sync_o <= 1'b0;
    end else begin
      pwm_o        <= pwm_nxt;
      frame_sync_o <= frame_last;  // high while both counters read zero
    end
  end

  // period counter wraps before the period length
  assert property (@(posedge adc_clk) disable iff (rst_i)
    per_cnt < PWM_CNT_W'(PWM_PERIOD));

endmodule

`default_nettype wire

//--- tb/analog_tb.sv
// analog front-end testbench, table-driven checks of ADC, DAC, handshake and PWM paths
`timescale 1ns/100ps
`default_nettype none

module analog_tb;

  import analog_pkg::*;

  localparam int TAB_N      = 4;                        // table entries
  localparam int RST_CYCLES = 16;
  localparam int RAND_N     = 12;                       // extra random ADC and DAC samples
  localparam int FRAME_CYC  = PWM_DITH_W * PWM_PERIOD;  // 2496 cycles
  localparam int LIMIT      = TAB_N * 3 * FRAME_CYC + 1000;
  localparam logic [ADC_W-1:0] SIGN_BIT = 14'h2000;     // msb flip mask

  // stimulus table, one entry per PWM channel
  localparam logic [ADC_W-1:0] ADC_A_TAB [TAB_N] = '{14'h3FFF, 14'h2000, 14'h1000, 14'h1FFF};
  localparam logic [ADC_W-1:0] ADC_B_TAB [TAB_N] = '{14'h0000, 14'h1FFF, 14'h0000, 14'h3FFF};
  localparam logic [DAC_W-1:0] DAC_A_TAB [TAB_N] =
    '{DAC_W'(500), DAC_W'(5000), DAC_W'(7000), DAC_W'(-7000)};
  localparam logic [DAC_W-1:0] DAC_B_TAB [TAB_N] =
    '{DAC_W'(-500), DAC_W'(-5000), DAC_W'(-7000), DAC_W'(7000)};
  localparam logic [PWM_WORD_W-1:0] PWM_TAB [TAB_N] =
    '{24'h000001, 24'h018001, 24'h9BFFFF, 24'h9C0000};  // duty 0, 1, 155, 156

  logic                  adc_clk;
  logic                  rst_i;
  logic [ADC_W-1:0]      adc_dat_a_i;
  logic [ADC_W-1:0]      adc_dat_b_i;
  logic [DAC_W-1:0]      dac_dat_a_i;
  logic [DAC_W-1:0]      dac_dat_b_i;
  logic                  cfg_req_i;
  logic [PWM_CH_W-1:0]   cfg_ch_i;
  logic [PWM_WORD_W-1:0] cfg_word_i;
  logic [ADC_W-1:0]      adc_dat_a_o;
  logic [ADC_W-1:0]      adc_dat_b_o;
  logic                  adc_ovr_a_o;
  logic                  adc_ovr_b_o;
  logic [DAC_W-1:0]      dac_dat_o;
  logic                  dac_wrt_o;
  logic                  dac_sel_o;
  logic [PWM_CH_N-1:0]   pwm_o;
  logic                  pwm_sync_o;
  logic                  cfg_ack_o;

  integer           seed;
  int               err_cnt;
  int               chk_cnt;
  int               test_err0;   // errors before the running test
  int               cycle_cnt;
  int               gap;         // cycles between syncs
  int               len;         // cycles in the counted frame
  int               hi [PWM_CH_N];
  logic [ADC_W-1:0] adc_a_s [$];  // ADC samples, table then random
  logic [ADC_W-1:0] adc_b_s [$];

  analog_top uut (.*);

  always #2 adc_clk = ~adc_clk;  // 4 ns period

  // run limit
  always @(posedge adc_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", LIMIT);
      $display("Something failed");
      $finish;
    end
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    chk_cnt++;
    if (expected !== actual) begin  // catches X too
      err_cnt++;
      $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic end_test(input string name);
    if (err_cnt == test_err0) $display("test %s passed", name);
    else $display("test %s failed with %0d errors", name, err_cnt - test_err0);
    test_err0 = err_cnt;
  endtask

  // code at either rail of the ADC range
  function automatic logic at_rail(input logic [ADC_W-1:0] x);
    return (x == '1) || (x == '0);
  endfunction

  // high cycles over one frame, each period clipped to its length
  function automatic int frame_high(input logic [PWM_WORD_W-1:0] word);
    int sum;
    int t;
    sum = 0;
    for (int k = 0; k < PWM_DITH_W; k++) begin
      t = int'(word[PWM_WORD_W-1 -: PWM_DUTY_W]) + int'(word[k]);
      if (t > PWM_PERIOD) t = PWM_PERIOD;
      sum += t;
    end
    return sum;
  endfunction

  // one sample per cycle, result expected two falling edges later
  task automatic run_adc;
    int n;
    n = adc_a_s.size();
    for (int i = 0; i < n + 2; i++) begin
      @(negedge adc_clk);
      if (i >= 2) begin
        check("adc_a", 32'(adc_a_s[i-2] ^ SIGN_BIT), 32'(adc_dat_a_o));
        check("adc_b", 32'(adc_b_s[i-2] ^ SIGN_BIT), 32'(adc_dat_b_o));
        check("adc_ovr_a", 32'(at_rail(adc_a_s[i-2])), 32'(adc_ovr_a_o));
        check("adc_ovr_b", 32'(at_rail(adc_b_s[i-2])), 32'(adc_ovr_b_o));
      end
      if (i < n) begin
        adc_dat_a_i = adc_a_s[i];
        adc_dat_b_i = adc_b_s[i];
      end
    end
  endtask

  task automatic dac_pair(input logic [DAC_W-1:0] a, input logic [DAC_W-1:0] b);
    @(negedge adc_clk);
    dac_dat_a_i = a;  // held until both slots seen
    dac_dat_b_i = b;
    @(negedge adc_clk);
    while (!dac_sel_o) @(negedge adc_clk);  // next A slot samples the new pair
    check("dac_wrt_a", 32'(1), 32'(dac_wrt_o));
    check("dac_a_slot", 32'(a ^ SIGN_BIT), 32'(dac_dat_o));
    @(negedge adc_clk);
    check("dac_sel_b", 32'(0), 32'(dac_sel_o));
    check("dac_wrt_b", 32'(1), 32'(dac_wrt_o));
    check("dac_b_slot", 32'(b ^ SIGN_BIT), 32'(dac_dat_o));
  endtask

  // four-phase write, ordering only
  task automatic write_cfg(input logic [PWM_CH_W-1:0] ch, input logic [PWM_WORD_W-1:0] word);
    @(negedge adc_clk);
    check("ack_before_req", 32'(0), 32'(cfg_ack_o));
    cfg_ch_i   = ch;
    cfg_word_i = word;
    cfg_req_i  = 1'b1;
    @(negedge adc_clk);
    while (!cfg_ack_o) @(negedge adc_clk);
    @(negedge adc_clk);
    check("ack_held_with_req", 32'(1), 32'(cfg_ack_o));  // no drop while req high
    cfg_req_i = 1'b0;
    @(negedge adc_clk);
    while (cfg_ack_o) @(negedge adc_clk);
  endtask

  task automatic wait_sync(output int cycles);
    cycles = 1;
    @(negedge adc_clk);
    while (!pwm_sync_o) begin
      @(negedge adc_clk);
      cycles++;
    end
  endtask

  initial begin
    seed        = 32'h8d294bc3;
    err_cnt     = 0;
    chk_cnt     = 0;
    test_err0   = 0;
    cycle_cnt   = 0;
    adc_clk     = 1'b0;
    rst_i       = 1'b1;
    adc_dat_a_i = 14'h2000;  // midscale, off the rails
    adc_dat_b_i = 14'h2000;
    dac_dat_a_i = '0;
    dac_dat_b_i = '0;
    cfg_req_i   = 1'b0;
    cfg_ch_i    = '0;
    cfg_word_i  = '0;

    for (int i = 0; i < RST_CYCLES; i++) begin
      @(negedge adc_clk);
      check("rst_ack", 32'(0), 32'(cfg_ack_o));
      check("rst_wrt", 32'(0), 32'(dac_wrt_o));
      check("rst_sel", 32'(0), 32'(dac_sel_o));
      check("rst_pwm", 32'(0), 32'(pwm_o));
      check("rst_sync", 32'(0), 32'(pwm_sync_o));
    end
    rst_i = 1'b0;
    @(negedge adc_clk);
    check("post_rst_ack", 32'(0), 32'(cfg_ack_o));  // first cycle out of reset
    check("post_rst_pwm", 32'(0), 32'(pwm_o));
    check("post_rst_sync", 32'(0), 32'(pwm_sync_o));
    end_test("reset");

    for (int i = 0; i < TAB_N; i++) begin
      adc_a_s.push_back(ADC_A_TAB[i]);
      adc_b_s.push_back(ADC_B_TAB[i]);
    end
    for (int i = 0; i < RAND_N; i++) begin
      adc_a_s.push_back(ADC_W'($random(seed)));
      adc_b_s.push_back(ADC_W'($random(seed)));
    end
    run_adc();
    end_test("adc_path");

    for (int i = 0; i < TAB_N; i++) dac_pair(DAC_A_TAB[i], DAC_B_TAB[i]);
    for (int i = 0; i < RAND_N; i++) dac_pair(DAC_W'($random(seed)), DAC_W'($random(seed)));
    end_test("dac_interleave");

    for (int i = 0; i < TAB_N; i++) write_cfg(PWM_CH_W'(i), PWM_TAB[i]);
    end_test("handshake");

    wait_sync(gap);  // shadow words go active here
    wait_sync(gap);
    check("sync_gap_first", 32'(FRAME_CYC), 32'(gap));
    for (int c = 0; c < PWM_CH_N; c++) hi[c] = 0;
    len = 0;
    do begin
      for (int c = 0; c < PWM_CH_N; c++) hi[c] += int'(pwm_o[c]);
      len++;
      @(negedge adc_clk);
    end while (!pwm_sync_o);
    for (int c = 0; c < PWM_CH_N; c++) begin
      check($sformatf("pwm_ch%0d_high", c), 32'(frame_high(PWM_TAB[c])), 32'(hi[c]));
    end
    end_test("pwm_duty_dither");

    check("frame_len", 32'(FRAME_CYC), 32'(len));
    wait_sync(gap);
    check("sync_gap_next", 32'(FRAME_CYC), 32'(gap));
    end_test("frame_sync");

    $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
design/analog_pkg.sv
design/adc_capture.sv
design/dac_interleave.sv
design/pwm_dac.sv
design/analog_ctrl.sv
design/analog_top.sv
tb/analog_tb.sv
